// ==== verilog/frontend_pkg.sv ====
// Common widths, bus types, register map and code conversion, referenced as frontend_pkg::name
package frontend_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int SMP_W     = 14;  // Sample and DAC code
  localparam int ADC_RAW_W = 16;  // Raw ADC word, low 2 bits reserved
  localparam int CFG_AW    = 3;   // Register address
  localparam int CFG_DW    = 32;  // Register data

  ////////////////////
  // Data and bus types
  ////////////////////

  typedef struct packed {
    logic [ADC_RAW_W-1:0] ch_b;
    logic [ADC_RAW_W-1:0] ch_a;
  } adc_raw_pair_t;

  typedef struct packed {
    logic signed [SMP_W-1:0] ch_b;
    logic signed [SMP_W-1:0] ch_a;
  } sample_pair_t;

  typedef struct packed {
    logic [SMP_W-1:0] ch_b;  // Negative slope, unsigned
    logic [SMP_W-1:0] ch_a;
  } dac_code_pair_t;

  typedef struct packed {
    logic              wr;     // One-cycle write strobe
    logic              rd;     // One-cycle read strobe
    logic [CFG_AW-1:0] addr;
    logic [CFG_DW-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic              ack;    // Pulses the cycle after an access
    logic [CFG_DW-1:0] rdata;
  } cfg_rsp_t;

  // Bit order as seen in REG_CFG
  typedef struct packed {
    logic trig_src_gen;  // Bit 2, generator trigger on n[0]
    logic trig_out_en;   // Bit 1, n[0] is trigger output
    logic digital_loop;  // Bit 0, DAC values into ADC path
  } fe_cfg_t;

  ////////////////////
  // Register map
  ////////////////////

  localparam logic [CFG_AW-1:0] REG_CFG       = 3'd0;
  localparam logic [CFG_AW-1:0] REG_P_DIR     = 3'd1;
  localparam logic [CFG_AW-1:0] REG_N_DIR     = 3'd2;
  localparam logic [CFG_AW-1:0] REG_P_OUT     = 3'd3;
  localparam logic [CFG_AW-1:0] REG_N_OUT     = 3'd4;
  localparam logic [CFG_AW-1:0] REG_P_IN      = 3'd5;  // Read only
  localparam logic [CFG_AW-1:0] REG_N_IN      = 3'd6;  // Read only
  localparam logic [CFG_AW-1:0] REG_LOCK_LOSS = 3'd7;  // Write clears

  // Negative slope conversion, same in both directions
  function automatic logic [SMP_W-1:0] neg_slope(input logic [SMP_W-1:0] val);
    return {val[SMP_W-1], ~val[SMP_W-2:0]};
  endfunction

endpackage

// ==== verilog/frontend_regs.sv ====
// Configuration register bank of the front end, with expansion pin registers and PLL lock-loss count
`timescale 1ns/1ps

module frontend_regs #(
  parameter int EXP_W = 8  // Expansion connector width
) (
  input  logic                   adc_clk,
  input  logic                   rst_i,
  input  frontend_pkg::cfg_req_t req_i,
  output frontend_pkg::cfg_rsp_t rsp_o,
  input  logic                   pll_locked_i,
  input  logic [EXP_W-1:0]       exp_p_in_i,   // Raw pin levels
  input  logic [EXP_W-1:0]       exp_n_in_i,
  output frontend_pkg::fe_cfg_t  cfg_o,
  output logic [EXP_W-1:0]       exp_p_dir_o,  // 1 = output
  output logic [EXP_W-1:0]       exp_n_dir_o,
  output logic [EXP_W-1:0]       exp_p_out_o,
  output logic [EXP_W-1:0]       exp_n_out_o
);

  localparam int CFG_BITS = $bits(frontend_pkg::fe_cfg_t);
  localparam int DW       = frontend_pkg::CFG_DW;

  logic [DW-1:0] lock_loss_cnt;  // Unlocked cycles
  logic [DW-1:0] rd_data;        // Read mux
  logic [DW-1:0] rdata_q;
  logic          ack_q;
  logic          clr_lock_loss;

  assign clr_lock_loss = req_i.wr && (req_i.addr == frontend_pkg::REG_LOCK_LOSS);

  ////////////////////
  // Register writes
  ////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      cfg_o       <= '0;
      exp_p_dir_o <= '0;  // All pins inputs
      exp_n_dir_o <= '0;
      exp_p_out_o <= '0;
      exp_n_out_o <= '0;
    end else if (req_i.wr) begin
      case (req_i.addr)
        frontend_pkg::REG_CFG:   cfg_o <= frontend_pkg::fe_cfg_t'(req_i.wdata[CFG_BITS-1:0]);
        frontend_pkg::REG_P_DIR: exp_p_dir_o <= req_i.wdata[EXP_W-1:0];
        frontend_pkg::REG_N_DIR: exp_n_dir_o <= req_i.wdata[EXP_W-1:0];
        frontend_pkg::REG_P_OUT: exp_p_out_o <= req_i.wdata[EXP_W-1:0];
        frontend_pkg::REG_N_OUT: exp_n_out_o <= req_i.wdata[EXP_W-1:0];
        default: ;  // Read-only, counter clear handled below
      endcase
    end
  end

  // Lock-loss counter, a write clears it
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      lock_loss_cnt <= '0;
    end else if (clr_lock_loss) begin
      lock_loss_cnt <= '0;
    end else if (!pll_locked_i) begin
      lock_loss_cnt <= lock_loss_cnt + 1'b1;
    end
  end

  ////////////////////
  // Read back
  ////////////////////

  always_comb begin
    rd_data = '0;  // Unmapped bits read zero
    case (req_i.addr)
      frontend_pkg::REG_CFG:       rd_data[CFG_BITS-1:0] = cfg_o;
      frontend_pkg::REG_P_DIR:     rd_data[EXP_W-1:0]    = exp_p_dir_o;
      frontend_pkg::REG_N_DIR:     rd_data[EXP_W-1:0]    = exp_n_dir_o;
      frontend_pkg::REG_P_OUT:     rd_data[EXP_W-1:0]    = exp_p_out_o;
      frontend_pkg::REG_N_OUT:     rd_data[EXP_W-1:0]    = exp_n_out_o;
      frontend_pkg::REG_P_IN:      rd_data[EXP_W-1:0]    = exp_p_in_i;  // Pins in read cycle
      frontend_pkg::REG_N_IN:      rd_data[EXP_W-1:0]    = exp_n_in_i;
      frontend_pkg::REG_LOCK_LOSS: rd_data               = lock_loss_cnt;
      default: ;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= req_i.wr | req_i.rd;  // Never stalls
  end

  always_ff @(posedge adc_clk) begin
    if (req_i.rd)
      rdata_q <= rd_data;
  end

  assign rsp_o.ack   = ack_q;
  assign rsp_o.rdata = rdata_q;

endmodule

// ==== verilog/adc_format.sv ====
// ADC input stage, turns raw negative-slope words into signed samples or selects DAC loopback
`timescale 1ns/1ps

module adc_format (
  input  logic                        adc_clk,
  input  logic                        rst_i,
  input  frontend_pkg::adc_raw_pair_t adc_raw_i,  // Raw 16-bit words
  input  frontend_pkg::sample_pair_t  mix_i,      // Saturated DAC sums
  input  logic                        loop_i,     // Digital loopback
  output frontend_pkg::sample_pair_t  adc_dat_o
);

  localparam int SMP_W = frontend_pkg::SMP_W;
  localparam int RAW_W = frontend_pkg::ADC_RAW_W;

  logic [SMP_W-1:0]           raw_a;  // Top 14 bits only
  logic [SMP_W-1:0]           raw_b;
  frontend_pkg::sample_pair_t adc_smp;

  ////////////////////
  // Decode
  ////////////////////

  // Low two bits are reserved
  assign raw_a = adc_raw_i.ch_a[RAW_W-1 -: SMP_W];
  assign raw_b = adc_raw_i.ch_b[RAW_W-1 -: SMP_W];

  // Offset binary with negative slope to two's complement
  assign adc_smp.ch_a = frontend_pkg::neg_slope(raw_a);
  assign adc_smp.ch_b = frontend_pkg::neg_slope(raw_b);

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i)
      adc_dat_o <= '0;
    else if (loop_i)
      adc_dat_o <= mix_i;  // ADC input ignored
    else
      adc_dat_o <= adc_smp;
  end

endmodule

// ==== verilog/dac_mix.sv ====
// DAC output stage, sums generator and controller samples, saturates and registers DAC codes
`timescale 1ns/1ps

module dac_mix (
  input  logic                         adc_clk,
  input  logic                         rst_i,
  input  frontend_pkg::sample_pair_t   gen_dat_i,  // Generator
  input  frontend_pkg::sample_pair_t   ctl_dat_i,  // Controller
  output frontend_pkg::sample_pair_t   mix_o,      // Saturated sums, combinational
  output frontend_pkg::dac_code_pair_t dac_dat_o   // Registered codes
);

  localparam int SMP_W = frontend_pkg::SMP_W;
  localparam int SUM_W = SMP_W + 1;  // One guard bit

  // Code of a zero sample
  localparam logic [SMP_W-1:0] ZERO_CODE = {1'b0, {(SMP_W-1){1'b1}}};

  logic [SUM_W-1:0] sum_a;
  logic [SUM_W-1:0] sum_b;

  // Clip to the 14-bit range when the two top bits disagree
  function automatic logic [SMP_W-1:0] sat(input logic [SUM_W-1:0] sum);
    if (sum[SUM_W-1] != sum[SUM_W-2])
      return {sum[SUM_W-1], {(SMP_W-1){~sum[SUM_W-1]}}};
    return sum[SMP_W-1:0];
  endfunction

  ////////////////////
  // Sum and saturate
  ////////////////////

  // Sign extend before adding
  assign sum_a = {gen_dat_i.ch_a[SMP_W-1], gen_dat_i.ch_a}
               + {ctl_dat_i.ch_a[SMP_W-1], ctl_dat_i.ch_a};
  assign sum_b = {gen_dat_i.ch_b[SMP_W-1], gen_dat_i.ch_b}
               + {ctl_dat_i.ch_b[SMP_W-1], ctl_dat_i.ch_b};

  assign mix_o.ch_a = sat(sum_a);
  assign mix_o.ch_b = sat(sum_b);

  ////////////////////
  // DAC code register
  ////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_dat_o.ch_a <= ZERO_CODE;  // Mid scale
      dac_dat_o.ch_b <= ZERO_CODE;
    end else begin
      dac_dat_o.ch_a <= frontend_pkg::neg_slope(mix_o.ch_a);
      dac_dat_o.ch_b <= frontend_pkg::neg_slope(mix_o.ch_b);
    end
  end

endmodule

// ==== verilog/exp_pin_mux.sv ====
// Expansion connector logic, pin overrides for the trigger output and external trigger synchronizer
`timescale 1ns/1ps

module exp_pin_mux #(
  parameter int EXP_W = 8  // Expansion connector width
) (
  input  logic                  adc_clk,
  input  logic                  rst_i,
  input  frontend_pkg::fe_cfg_t cfg_i,
  input  logic [EXP_W-1:0]      p_dir_i,       // From register bank
  input  logic [EXP_W-1:0]      n_dir_i,
  input  logic [EXP_W-1:0]      p_out_i,
  input  logic [EXP_W-1:0]      n_out_i,
  input  logic [EXP_W-1:0]      p_pin_i,       // Pin levels
  input  logic [EXP_W-1:0]      n_pin_i,
  input  logic                  scope_trig_i,
  input  logic                  gen_trig_i,
  output logic [EXP_W-1:0]      p_pin_o,
  output logic [EXP_W-1:0]      n_pin_o,
  output logic [EXP_W-1:0]      p_oe_o,        // 1 = drive pin
  output logic [EXP_W-1:0]      n_oe_o,
  output logic [EXP_W-1:0]      p_in_o,        // Raw levels for read back
  output logic [EXP_W-1:0]      n_in_o,
  output logic                  trig_ext_o     // Synchronized p[0]
);

  logic             trig_sel;   // Trigger routed to n[0]
  logic [EXP_W-1:0] n_alt;      // Pins taken by alternate function
  logic [1:0]       trig_sync;

  assign trig_sel = cfg_i.trig_src_gen ? gen_trig_i : scope_trig_i;
  assign n_alt    = {{(EXP_W-1){1'b0}}, cfg_i.trig_out_en};  // Only n[0] has one

  ////////////////////
  // Pin drive
  ////////////////////

  assign p_pin_o = p_out_i;
  assign p_oe_o  = p_dir_i;

  // Alternate function overrides data and forces output
  assign n_pin_o = (n_out_i & ~n_alt) | ({EXP_W{trig_sel}} & n_alt);
  assign n_oe_o  = n_dir_i | n_alt;

  assign p_in_o = p_pin_i;
  assign n_in_o = n_pin_i;

  ////////////////////
  // External trigger
  ////////////////////

  // Two flops, p[0] is asynchronous
  always_ff @(posedge adc_clk) begin
    if (rst_i)
      trig_sync <= '0;
    else
      trig_sync <= {trig_sync[0], p_pin_i[0]};
  end

  assign trig_ext_o = trig_sync[1];

endmodule

// ==== verilog/frontend_top.sv ====
// Top level of the two-channel analog front end, connects register bank, ADC, DAC and pin logic
`timescale 1ns/1ps

module frontend_top #(
  parameter int EXP_W = 8  // Expansion connector width, 8 or 11
) (
  input  logic                         adc_clk,
  input  logic                         rst_i,
  // ADC and DAC data
  input  frontend_pkg::adc_raw_pair_t  adc_dat_i,
  input  frontend_pkg::sample_pair_t   gen_dat_i,     // Generator samples
  input  frontend_pkg::sample_pair_t   ctl_dat_i,     // Controller samples
  output frontend_pkg::sample_pair_t   adc_dat_o,
  output frontend_pkg::dac_code_pair_t dac_dat_o,
  // Triggers and status
  input  logic                         scope_trig_i,
  input  logic                         gen_trig_i,
  input  logic                         pll_locked_i,
  output logic                         trig_ext_o,
  // Register bus
  input  frontend_pkg::cfg_req_t       cfg_req_i,
  output frontend_pkg::cfg_rsp_t       cfg_rsp_o,
  // Expansion connector
  input  logic [EXP_W-1:0]             exp_p_i,
  input  logic [EXP_W-1:0]             exp_n_i,
  output logic [EXP_W-1:0]             exp_p_o,
  output logic [EXP_W-1:0]             exp_n_o,
  output logic [EXP_W-1:0]             exp_p_oe_o,
  output logic [EXP_W-1:0]             exp_n_oe_o
);

  frontend_pkg::fe_cfg_t      cfg;
  frontend_pkg::sample_pair_t mix;  // Saturated sums for loopback
  logic [EXP_W-1:0]           p_dir;
  logic [EXP_W-1:0]           n_dir;
  logic [EXP_W-1:0]           p_out;
  logic [EXP_W-1:0]           n_out;
  logic [EXP_W-1:0]           p_in;
  logic [EXP_W-1:0]           n_in;

  ////////////////////
  // Control
  ////////////////////

  frontend_regs #(.EXP_W(EXP_W)) i_regs (
    .adc_clk      (adc_clk),
    .rst_i        (rst_i),
    .req_i        (cfg_req_i),
    .rsp_o        (cfg_rsp_o),
    .pll_locked_i (pll_locked_i),
    .exp_p_in_i   (p_in),
    .exp_n_in_i   (n_in),
    .cfg_o        (cfg),
    .exp_p_dir_o  (p_dir),
    .exp_n_dir_o  (n_dir),
    .exp_p_out_o  (p_out),
    .exp_n_out_o  (n_out)
  );

  ////////////////////
  // Sample paths
  ////////////////////

  adc_format i_adc_format (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .adc_raw_i (adc_dat_i),
    .mix_i     (mix),
    .loop_i    (cfg.digital_loop),
    .adc_dat_o (adc_dat_o)
  );

  dac_mix i_dac_mix (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .gen_dat_i (gen_dat_i),
    .ctl_dat_i (ctl_dat_i),
    .mix_o     (mix),
    .dac_dat_o (dac_dat_o)
  );

  ////////////////////
  // Expansion pins
  ////////////////////

  exp_pin_mux #(.EXP_W(EXP_W)) i_exp_pin_mux (
    .adc_clk      (adc_clk),
    .rst_i        (rst_i),
    .cfg_i        (cfg),
    .p_dir_i      (p_dir),
    .n_dir_i      (n_dir),
    .p_out_i      (p_out),
    .n_out_i      (n_out),
    .p_pin_i      (exp_p_i),
    .n_pin_i      (exp_n_i),
    .scope_trig_i (scope_trig_i),
    .gen_trig_i   (gen_trig_i),
    .p_pin_o      (exp_p_o),
    .n_pin_o      (exp_n_o),
    .p_oe_o       (exp_p_oe_o),
    .n_oe_o       (exp_n_oe_o),
    .p_in_o       (p_in),   // Back to register bank
    .n_in_o       (n_in),
    .trig_ext_o   (trig_ext_o)
  );

endmodule

// ==== sim/tb_frontend_vectors.svh ====
// Sample path table for the front end testbench, included inside tb_frontend_top
`ifndef TB_FRONTEND_VECTORS_SVH
`define TB_FRONTEND_VECTORS_SVH

  // One row of stimulus, mix_a and mix_b hold the expected saturated sums
  typedef struct packed {
    logic signed [SMP_W-1:0] gen_a;
    logic signed [SMP_W-1:0] ctl_a;
    logic signed [SMP_W-1:0] gen_b;
    logic signed [SMP_W-1:0] ctl_b;
    logic [RAW_W-1:0]        raw_a;  // Raw ADC words
    logic [RAW_W-1:0]        raw_b;
    logic                    loop;   // Digital loopback on
    logic signed [SMP_W-1:0] mix_a;
    logic signed [SMP_W-1:0] mix_b;
  } vec_row_t;

  localparam int NUM_VEC = 12;  // Rows in load_vectors

  vec_row_t vec_rows[$];

  task automatic add_row(input int gen_a, input int ctl_a, input int gen_b, input int ctl_b,
                         input int raw_a, input int raw_b, input bit loop,
                         input int mix_a, input int mix_b);
    vec_row_t r;
    r.gen_a = SMP_W'(gen_a);
    r.ctl_a = SMP_W'(ctl_a);
    r.gen_b = SMP_W'(gen_b);
    r.ctl_b = SMP_W'(ctl_b);
    r.raw_a = RAW_W'(raw_a);
    r.raw_b = RAW_W'(raw_b);
    r.loop  = loop;
    r.mix_a = SMP_W'(mix_a);
    r.mix_b = SMP_W'(mix_b);
    vec_rows.push_back(r);
  endtask

  task automatic load_vectors();
    //      gen_a  ctl_a  gen_b  ctl_b  raw_a     raw_b     loop  mix_a  mix_b
    add_row(    0,     0,     0,     0, 16'h7FFC, 16'h7FFC, 1'b0,     0,     0);  // Mid scale
    add_row(  100,    50,  -200,   300, 16'h0000, 16'hFFFC, 1'b0,   150,   100);  // ADC extremes
    add_row(-3000,  1000,  2500, -2500, 16'h8000, 16'h4000, 1'b0, -2000,     0);
    add_row( 8191,     1, -8192,    -1, 16'h1234, 16'hABCD, 1'b0,  8191, -8192);
    add_row( 5000,  5000, -5000, -5000, 16'hFFFF, 16'h0003, 1'b0,  8191, -8192);
    add_row( 4095,  4096, -4096, -4096, 16'h2468, 16'h9BDF, 1'b0,  8191, -8192);  // Exact limits
    add_row( 4096,  4096, -4097, -4096, 16'h0000, 16'h0000, 1'b0,  8191, -8192);  // One past
    // Loopback rows, raw words must be ignored
    add_row( 1234,  -234, -4000,  4100, 16'h0000, 16'hFFFC, 1'b1,  1000,   100);
    add_row( 8191,  8191, -8192, -8192, 16'h5555, 16'hAAAA, 1'b1,  8191, -8192);
    add_row(   -1,     0,     1,     0, 16'h7FFC, 16'h7FFC, 1'b1,    -1,     1);
    add_row(-8192,  8191,  8191, -8192, 16'h1111, 16'hEEEE, 1'b1,    -1,    -1);
    add_row(    7,    -7,    13,     0, 16'hFFFF, 16'h0003, 1'b0,     0,    13);  // Loop off again
  endtask

`endif

// ==== sim/tb_frontend_top.sv ====
// Self-checking testbench for the front end top level, compiled through all.f and run by run_sim.sh
`timescale 1ns/1ps

module tb_frontend_top;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int EXP_W        = 8;  // DUT default
  localparam int SMP_W        = frontend_pkg::SMP_W;
  localparam int RAW_W        = frontend_pkg::ADC_RAW_W;
  localparam int SMP_MAX      = 2 ** (SMP_W - 1) - 1;
  localparam int SMP_MIN      = -(2 ** (SMP_W - 1));
  localparam int NUM_RAND     = 40;  // Random rows after the table
  localparam int LOCK_CYCLES  = 13;  // PLL held unlocked
  localparam int REG_CYCLES   = 60 + LOCK_CYCLES;  // Register, pin and trigger sequence

  // REG_CFG bits
  localparam logic [31:0] CFG_LOOP     = 32'h1;
  localparam logic [31:0] CFG_TRIG_OUT = 32'h2;
  localparam logic [31:0] CFG_TRIG_GEN = 32'h4;

  localparam logic [EXP_W-1:0] P_DIR_VAL = 8'hA5;
  localparam logic [EXP_W-1:0] P_OUT_VAL = 8'h3C;
  localparam logic [EXP_W-1:0] N_DIR_VAL = 8'h0E;  // n[0] left an input
  localparam logic [EXP_W-1:0] N_OUT_VAL = 8'h96;
  localparam logic [EXP_W-1:0] P_PIN_VAL = 8'h5A;  // Bit 0 low, trigger idle
  localparam logic [EXP_W-1:0] N_PIN_VAL = 8'hC3;
  localparam logic [EXP_W-1:0] N0_MASK   = EXP_W'(1);

  `include "tb_frontend_vectors.svh"

  // At most two cycles per row, doubled for margin
  localparam int  RUN_CYCLES    = RESET_CYCLES + 2 * (NUM_VEC + NUM_RAND) + REG_CYCLES;
  localparam time WATCHDOG_TIME = 2 * RUN_CYCLES * CLK_PERIOD;

  logic                         adc_clk;
  logic                         rst;
  frontend_pkg::adc_raw_pair_t  adc_raw;
  frontend_pkg::sample_pair_t   gen_dat;
  frontend_pkg::sample_pair_t   ctl_dat;
  frontend_pkg::sample_pair_t   adc_dat;
  frontend_pkg::dac_code_pair_t dac_dat;
  logic                         scope_trig;
  logic                         gen_trig;
  logic                         pll_locked;
  logic                         trig_ext;
  frontend_pkg::cfg_req_t       cfg_req;
  frontend_pkg::cfg_rsp_t       cfg_rsp;
  logic [EXP_W-1:0]             exp_p_in;
  logic [EXP_W-1:0]             exp_n_in;
  logic [EXP_W-1:0]             exp_p_out;
  logic [EXP_W-1:0]             exp_n_out;
  logic [EXP_W-1:0]             exp_p_oe;
  logic [EXP_W-1:0]             exp_n_oe;

  integer      seed;
  int          err_cnt;
  int          row_cnt;
  int          acc_cnt;   // Register accesses
  logic        cur_loop;  // Loopback bit last written
  logic [31:0] rd_val;
  vec_row_t    rnd_row;

  frontend_pkg::sample_pair_t   prev_adc;  // Outputs expected from the last row
  frontend_pkg::dac_code_pair_t prev_dac;

  frontend_top i_frontend_top (
    .adc_clk      (adc_clk),
    .rst_i        (rst),
    .adc_dat_i    (adc_raw),
    .gen_dat_i    (gen_dat),
    .ctl_dat_i    (ctl_dat),
    .adc_dat_o    (adc_dat),
    .dac_dat_o    (dac_dat),
    .scope_trig_i (scope_trig),
    .gen_trig_i   (gen_trig),
    .pll_locked_i (pll_locked),
    .trig_ext_o   (trig_ext),
    .cfg_req_i    (cfg_req),
    .cfg_rsp_o    (cfg_rsp),
    .exp_p_i      (exp_p_in),
    .exp_n_i      (exp_n_in),
    .exp_p_o      (exp_p_out),
    .exp_n_o      (exp_n_out),
    .exp_p_oe_o   (exp_p_oe),
    .exp_n_oe_o   (exp_n_oe)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Top 14 bits, sign kept and the rest inverted
  function automatic logic signed [SMP_W-1:0] adc_decode(input logic [RAW_W-1:0] raw);
    return {raw[RAW_W-1], ~raw[RAW_W-2:2]};
  endfunction

  function automatic logic [SMP_W-1:0] dac_encode(input logic signed [SMP_W-1:0] smp);
    return {smp[SMP_W-1], ~smp[SMP_W-2:0]};
  endfunction

  function automatic logic signed [SMP_W-1:0] clip_sum(input int a, input int b);
    int sum;
    sum = a + b;  // Integer math, no overflow
    if (sum > SMP_MAX)
      sum = SMP_MAX;
    else if (sum < SMP_MIN)
      sum = SMP_MIN;
    return SMP_W'(sum);
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] expected);
    err_cnt++;
    $display("[FAIL] t=%0t %s: got %0h, expected %0h", $realtime, what, got, expected);
  endtask

  task automatic make_random_row(output vec_row_t r);
    logic [31:0] tmp;
    r.gen_a = SMP_W'($random(seed));
    r.ctl_a = SMP_W'($random(seed));
    r.gen_b = SMP_W'($random(seed));
    r.ctl_b = SMP_W'($random(seed));
    r.raw_a = RAW_W'($random(seed));
    r.raw_b = RAW_W'($random(seed));
    tmp     = $random(seed);
    r.loop  = tmp[0];
    r.mix_a = clip_sum(r.gen_a, r.ctl_a);
    r.mix_b = clip_sum(r.gen_b, r.ctl_b);
  endtask

  ////////////////////
  // Bus and row tasks
  ////////////////////

  // Start and end on a falling edge
  task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
    cfg_req.wr    = 1'b1;
    cfg_req.addr  = addr;
    cfg_req.wdata = data;
    @(negedge adc_clk);
    cfg_req = '0;
    acc_cnt++;
    if (cfg_rsp.ack !== 1'b1) report_mismatch($sformatf("write ack, addr %0d", addr),
                                              cfg_rsp.ack, 32'h1);
  endtask

  task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
    cfg_req.rd   = 1'b1;
    cfg_req.addr = addr;
    @(negedge adc_clk);
    cfg_req = '0;
    acc_cnt++;
    if (cfg_rsp.ack !== 1'b1) report_mismatch($sformatf("read ack, addr %0d", addr),
                                              cfg_rsp.ack, 32'h1);
    data = cfg_rsp.rdata;
  endtask

  task automatic apply_row(input vec_row_t r);
    frontend_pkg::sample_pair_t exp_adc;
    if (r.loop != cur_loop) begin
      write_reg(frontend_pkg::REG_CFG, r.loop ? CFG_LOOP : 32'h0);
      cur_loop = r.loop;
    end
    gen_dat.ch_a = r.gen_a;
    gen_dat.ch_b = r.gen_b;
    ctl_dat.ch_a = r.ctl_a;
    ctl_dat.ch_b = r.ctl_b;
    adc_raw.ch_a = r.raw_a;
    adc_raw.ch_b = r.raw_b;
    #(CLK_PERIOD / 4);  // Ahead of the rising edge, last row still shown
    if (adc_dat !== prev_adc)
      report_mismatch($sformatf("row %0d adc before edge", row_cnt + 1), adc_dat, prev_adc);
    if (dac_dat !== prev_dac)
      report_mismatch($sformatf("row %0d dac before edge", row_cnt + 1), dac_dat, prev_dac);
    @(negedge adc_clk);  // One rising edge later
    row_cnt++;
    if (r.loop) begin
      exp_adc.ch_a = r.mix_a;  // Raw input ignored
      exp_adc.ch_b = r.mix_b;
    end else begin
      exp_adc.ch_a = adc_decode(r.raw_a);
      exp_adc.ch_b = adc_decode(r.raw_b);
    end
    if (adc_dat.ch_a !== exp_adc.ch_a)
      report_mismatch($sformatf("row %0d adc ch_a", row_cnt), adc_dat.ch_a, exp_adc.ch_a);
    if (adc_dat.ch_b !== exp_adc.ch_b)
      report_mismatch($sformatf("row %0d adc ch_b", row_cnt), adc_dat.ch_b, exp_adc.ch_b);
    if (dac_dat.ch_a !== dac_encode(r.mix_a))
      report_mismatch($sformatf("row %0d dac ch_a", row_cnt), dac_dat.ch_a, dac_encode(r.mix_a));
    if (dac_dat.ch_b !== dac_encode(r.mix_b))
      report_mismatch($sformatf("row %0d dac ch_b", row_cnt), dac_dat.ch_b, dac_encode(r.mix_b));
    prev_adc      = exp_adc;
    prev_dac.ch_a = dac_encode(r.mix_a);
    prev_dac.ch_b = dac_encode(r.mix_b);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    seed       = 32'hed6f;
    rst        = 1'b1;
    adc_raw    = '0;
    gen_dat    = '0;
    ctl_dat    = '0;
    scope_trig = 1'b0;
    gen_trig   = 1'b0;
    pll_locked = 1'b1;
    cfg_req    = '0;
    exp_p_in   = '0;
    exp_n_in   = '0;
    err_cnt    = 0;
    row_cnt    = 0;
    acc_cnt    = 0;
    cur_loop   = 1'b0;
    prev_adc   = '0;  // Reset values
    prev_dac.ch_a = dac_encode('0);
    prev_dac.ch_b = dac_encode('0);

    repeat (RESET_CYCLES) @(posedge adc_clk);
    @(negedge adc_clk);
    rst = 1'b0;

    // Still reset values, no rising edge since release
    if (cfg_rsp.ack !== 1'b0) report_mismatch("ack after reset", cfg_rsp.ack, 32'h0);
    if (adc_dat !== '0) report_mismatch("adc after reset", adc_dat, 32'h0);
    if (dac_dat.ch_a !== dac_encode('0)) report_mismatch("dac ch_a after reset",
                                                         dac_dat.ch_a, dac_encode('0));
    if (dac_dat.ch_b !== dac_encode('0)) report_mismatch("dac ch_b after reset",
                                                         dac_dat.ch_b, dac_encode('0));
    if (exp_p_oe !== '0) report_mismatch("exp_p_oe after reset", exp_p_oe, 32'h0);
    if (exp_n_oe !== '0) report_mismatch("exp_n_oe after reset", exp_n_oe, 32'h0);
    if (exp_p_out !== '0) report_mismatch("exp_p_o after reset", exp_p_out, 32'h0);
    if (exp_n_out !== '0) report_mismatch("exp_n_o after reset", exp_n_out, 32'h0);
    if (trig_ext !== 1'b0) report_mismatch("trig_ext after reset", trig_ext, 32'h0);

    // Table first, then random rows
    load_vectors();
    if (vec_rows.size() != NUM_VEC) begin
      err_cnt++;
      $display("ERROR: vector table holds %0d rows instead of %0d", vec_rows.size(), NUM_VEC);
    end
    for (int i = 0; i < NUM_RAND; i++) begin
      make_random_row(rnd_row);
      vec_rows.push_back(rnd_row);
    end
    foreach (vec_rows[i]) apply_row(vec_rows[i]);

    ////////////////////
    // Registers and pins
    ////////////////////

    write_reg(frontend_pkg::REG_P_DIR, 32'(P_DIR_VAL));
    write_reg(frontend_pkg::REG_P_OUT, 32'(P_OUT_VAL));
    write_reg(frontend_pkg::REG_N_DIR, 32'(N_DIR_VAL));
    write_reg(frontend_pkg::REG_N_OUT, 32'(N_OUT_VAL));
    if (exp_p_oe !== P_DIR_VAL) report_mismatch("exp_p_oe", exp_p_oe, 32'(P_DIR_VAL));
    if (exp_p_out !== P_OUT_VAL) report_mismatch("exp_p_o", exp_p_out, 32'(P_OUT_VAL));
    if (exp_n_oe !== N_DIR_VAL) report_mismatch("exp_n_oe", exp_n_oe, 32'(N_DIR_VAL));
    if (exp_n_out !== N_OUT_VAL) report_mismatch("exp_n_o", exp_n_out, 32'(N_OUT_VAL));
    read_reg(frontend_pkg::REG_P_DIR, rd_val);
    if (rd_val !== 32'(P_DIR_VAL)) report_mismatch("REG_P_DIR read", rd_val, 32'(P_DIR_VAL));
    read_reg(frontend_pkg::REG_N_OUT, rd_val);
    if (rd_val !== 32'(N_OUT_VAL)) report_mismatch("REG_N_OUT read", rd_val, 32'(N_OUT_VAL));
    @(negedge adc_clk);
    if (cfg_rsp.ack !== 1'b0) report_mismatch("ack longer than one cycle", cfg_rsp.ack, 32'h0);

    exp_p_in = P_PIN_VAL;
    exp_n_in = N_PIN_VAL;
    read_reg(frontend_pkg::REG_P_IN, rd_val);
    if (rd_val !== 32'(P_PIN_VAL)) report_mismatch("REG_P_IN read", rd_val, 32'(P_PIN_VAL));
    read_reg(frontend_pkg::REG_N_IN, rd_val);
    if (rd_val !== 32'(N_PIN_VAL)) report_mismatch("REG_N_IN read", rd_val, 32'(N_PIN_VAL));
    write_reg(frontend_pkg::REG_P_IN, 32'hFF);  // Read only
    read_reg(frontend_pkg::REG_P_IN, rd_val);
    if (rd_val !== 32'(P_PIN_VAL)) report_mismatch("REG_P_IN after write", rd_val,
                                                   32'(P_PIN_VAL));

    ////////////////////
    // Triggers
    ////////////////////

    write_reg(frontend_pkg::REG_CFG, CFG_TRIG_OUT);  // Scope trigger on n[0]
    scope_trig = 1'b1;
    @(negedge adc_clk);
    if (exp_n_oe !== (N_DIR_VAL | N0_MASK))
      report_mismatch("exp_n_oe with trigger out", exp_n_oe, 32'(N_DIR_VAL | N0_MASK));
    if (exp_n_out !== ((N_OUT_VAL & ~N0_MASK) | N0_MASK))
      report_mismatch("n[0] scope trigger high", exp_n_out, 32'(N_OUT_VAL | N0_MASK));
    scope_trig = 1'b0;
    gen_trig   = 1'b1;  // Not selected yet
    @(negedge adc_clk);
    if (exp_n_out !== (N_OUT_VAL & ~N0_MASK))
      report_mismatch("n[0] scope trigger low", exp_n_out, 32'(N_OUT_VAL & ~N0_MASK));
    write_reg(frontend_pkg::REG_CFG, CFG_TRIG_OUT | CFG_TRIG_GEN);
    if (exp_n_out !== ((N_OUT_VAL & ~N0_MASK) | N0_MASK))
      report_mismatch("n[0] generator trigger", exp_n_out, 32'(N_OUT_VAL | N0_MASK));

    // External trigger through two flops
    if (trig_ext !== 1'b0) report_mismatch("trig_ext idle", trig_ext, 32'h0);
    exp_p_in[0] = 1'b1;
    @(negedge adc_clk);
    if (trig_ext !== 1'b0) report_mismatch("trig_ext rise, one cycle", trig_ext, 32'h0);
    @(negedge adc_clk);
    if (trig_ext !== 1'b1) report_mismatch("trig_ext rise, two cycles", trig_ext, 32'h1);
    exp_p_in[0] = 1'b0;
    @(negedge adc_clk);
    if (trig_ext !== 1'b1) report_mismatch("trig_ext fall, one cycle", trig_ext, 32'h1);
    @(negedge adc_clk);
    if (trig_ext !== 1'b0) report_mismatch("trig_ext fall, two cycles", trig_ext, 32'h0);

    // Lock-loss counter, zero since reset
    pll_locked = 1'b0;
    repeat (LOCK_CYCLES) @(negedge adc_clk);
    pll_locked = 1'b1;
    read_reg(frontend_pkg::REG_LOCK_LOSS, rd_val);
    if (rd_val !== 32'(LOCK_CYCLES)) report_mismatch("lock-loss count", rd_val,
                                                     32'(LOCK_CYCLES));
    write_reg(frontend_pkg::REG_LOCK_LOSS, 32'h0);
    read_reg(frontend_pkg::REG_LOCK_LOSS, rd_val);
    if (rd_val !== 32'h0) report_mismatch("lock-loss after clear", rd_val, 32'h0);

    $display("Done: %0d sample rows, %0d register accesses, %0d errors",
             row_cnt, acc_cnt, err_cnt);
    if (err_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_TIME);
    $display("ERROR: watchdog expired at %0t, the test sequence did not finish", $realtime);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+sim
verilog/frontend_pkg.sv
verilog/frontend_regs.sv
verilog/adc_format.sv
verilog/dac_mix.sv
verilog/exp_pin_mux.sv
verilog/frontend_top.sv
sim/tb_frontend_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the front end with Verilator, run the testbench and check the log
set -e
set -o pipefail
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal \
  --top-module tb_frontend_top \
  -f all.f \
  -o tb_frontend_top

./obj_dir/tb_frontend_top | tee "$LOG"

if grep -qx "SIMULATION PASSED" "$LOG"; then
  echo "Result: pass"
else
  echo "Result: fail"
  exit 1
fi
